// File: vlog.f
conv2d_pkg.sv
conv_halo_gen.sv
conv_line_buffer.sv
conv_pe.sv
conv_pe_array.sv
conv_fifo.sv
conv2d_top.sv
conv2d_props.sv
tb_conv2d.sv

// File: Bender.yml
package:
  name: conv2d

sources:
  - conv2d_pkg.sv
  - conv_halo_gen.sv
  - conv_line_buffer.sv
  - conv_pe.sv
  - conv_pe_array.sv
  - conv_fifo.sv
  - conv2d_top.sv
  - target: test
    files:
      - conv2d_props.sv
      - tb_conv2d.sv

// File: tb_conv2d.sv
// testbench with clock, reset, stream stimulus, reference model, compare process and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_conv2d;

    localparam int FM_MAX     = 8;
    localparam int FIFO_DEPTH = 8;
    localparam int CLK_PERIOD = 8;
    localparam int WT_DIM     = conv2d_pkg::WT_DIM;
    localparam int PAD        = conv2d_pkg::PAD;
    localparam int PAD_FRAME  = (FM_MAX + WT_DIM - 1) * (FM_MAX + WT_DIM - 1);

    // frame sides used by the tests in run order
    localparam int DIM_T1  = 4;
    localparam int DIM_T2  = 5;
    localparam int DIM_T3A = 3;
    localparam int DIM_T3B = 6;
    localparam int DIM_T4  = 6;
    localparam int DIM_T5  = 5;

    logic                  clk;
    logic                  arst_n_i;
    conv2d_pkg::coord_t    fm_dim_i;
    conv2d_pkg::data_t     wt_data_i;
    logic                  wt_valid_i;
    logic                  wt_ready_o;
    conv2d_pkg::data_t     fm_data_i;
    logic                  fm_valid_i;
    logic                  fm_ready_o;
    conv2d_pkg::res_beat_t res_o;
    logic                  res_valid_o;
    logic                  res_ready_i;

    int                    seed = 42;
    logic                  bp_on;
    string                 test_name;
    int                    got_cnt;
    int                    err_cnt;
    int                    base_got;
    int                    base_err;
    int                    tests_run;
    conv2d_pkg::data_t     kern [WT_DIM*WT_DIM];
    conv2d_pkg::data_t     fm_mem [FM_MAX*FM_MAX];
    conv2d_pkg::res_beat_t exp_q [$];

    conv2d_top #(
        .FM_MAX     (FM_MAX),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .fm_dim_i    (fm_dim_i),
        .wt_data_i   (wt_data_i),
        .wt_valid_i  (wt_valid_i),
        .wt_ready_o  (wt_ready_o),
        .fm_data_i   (fm_data_i),
        .fm_valid_i  (fm_valid_i),
        .fm_ready_o  (fm_ready_o),
        .res_o       (res_o),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i)
    );

    bind conv2d_top conv2d_props u_props (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .wt_data_i        (wt_data_i),
        .wt_valid_i       (wt_valid_i),
        .wt_ready_i       (wt_ready_o),
        .fm_data_i        (fm_data_i),
        .fm_valid_i       (fm_valid_i),
        .fm_ready_i       (fm_ready_o),
        .res_data_i       (res_o),
        .res_valid_i      (res_valid_o),
        .res_ready_i      (res_ready_i),
        .weights_loaded_i (weights_loaded)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // zero-padded same cross-correlation where every product and sum wraps at 16 bits
    function automatic void conv_ref(input int dim);
        conv2d_pkg::data_t     acc;
        conv2d_pkg::data_t     px;
        conv2d_pkg::res_beat_t beat;
        int                    py;
        int                    pc;
        for (int y = 0; y < dim; y++) begin
            for (int x = 0; x < dim; x++) begin
                acc = '0;
                for (int m = 0; m < WT_DIM; m++) begin
                    for (int n = 0; n < WT_DIM; n++) begin
                        py = y + m - PAD;
                        pc = x + n - PAD;
                        if (py >= 0 && py < dim && pc >= 0 && pc < dim) begin
                            px = fm_mem[py * dim + pc];
                        end else begin
                            px = '0;
                        end
                        acc = acc + kern[m * WT_DIM + n] * px;
                    end
                end
                beat.data = acc;
                beat.last = (y == dim - 1) && (x == dim - 1);
                exp_q.push_back(beat);
            end
        end
    endfunction

    function automatic int frame_beats(input int dim);
        return WT_DIM * WT_DIM + 2 * dim * dim;
    endfunction

    function automatic void randomize_kernel(input conv2d_pkg::data_t and_mask,
                                             input conv2d_pkg::data_t or_mask);
        for (int i = 0; i < WT_DIM * WT_DIM; i++) begin
            kern[i] = (conv2d_pkg::data_t'($random(seed)) & and_mask) | or_mask;
        end
    endfunction

    function automatic void randomize_map(input int dim, input conv2d_pkg::data_t and_mask,
                                          input conv2d_pkg::data_t or_mask);
        for (int i = 0; i < dim * dim; i++) begin
            fm_mem[i] = (conv2d_pkg::data_t'($random(seed)) & and_mask) | or_mask;
        end
    endfunction

    // waits until the engine takes a kernel, then fixes the frame side and loads it
    task automatic send_weights(input int dim);
        while (!wt_ready_o) begin
            @(negedge clk);
        end
        fm_dim_i = conv2d_pkg::coord_t'(dim);
        for (int i = 0; i < WT_DIM * WT_DIM; i++) begin
            while (($random(seed) & 3) == 0) begin
                @(negedge clk);
            end
            wt_data_i  = kern[i];
            wt_valid_i = 1'b1;
            #1;
            while (!wt_ready_o) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
            wt_valid_i = 1'b0;
        end
    endtask

    task automatic send_frame(input int dim);
        for (int i = 0; i < dim * dim; i++) begin
            while (($random(seed) & 3) == 0) begin
                @(negedge clk);
            end
            fm_data_i  = fm_mem[i];
            fm_valid_i = 1'b1;
            #1;
            while (!fm_ready_o) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
            fm_valid_i = 1'b0;
        end
    endtask

    task automatic run_frame(input int dim);
        conv_ref(dim);
        send_weights(dim);
        send_frame(dim);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        base_got  = got_cnt;
        base_err  = err_cnt;
    endtask

    task automatic finish_test(input int exp_cnt);
        // a result still left in the FIFO after the expected ones is an extra
        while (exp_q.size() != 0 || res_valid_o) begin
            @(negedge clk);
        end
        if (got_cnt - base_got != exp_cnt) begin
            $display("[FAIL] %s result count: expected %0d, actual %0d",
                     test_name, exp_cnt, got_cnt - base_got);
            err_cnt++;
        end
        tests_run++;
        $display("test %s done: %0d results, %0d errors",
                 test_name, got_cnt - base_got, err_cnt - base_err);
    endtask

    initial begin : ready_drive
        res_ready_i = 1'b0;
        forever begin
            @(negedge clk);
            res_ready_i = bp_on ? 1'($random(seed)) : 1'b1;
        end
    end

    // a result moves at the next rising edge when valid and ready are both high here
    initial begin : compare
        conv2d_pkg::res_beat_t exp_beat;
        forever begin
            @(negedge clk);
            #1;
            if (res_valid_o && res_ready_i) begin
                got_cnt++;
                if (exp_q.size() == 0) begin
                    $display("error: %s produced a result that was not expected", test_name);
                    err_cnt++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (res_o.data !== exp_beat.data) begin
                        $display("[FAIL] %s result %0d: expected %h, actual %h", test_name,
                                 got_cnt - base_got, exp_beat.data, res_o.data);
                        err_cnt++;
                    end
                    if (res_o.last !== exp_beat.last) begin
                        $display("[FAIL] %s result %0d last: expected %0b, actual %0b", test_name,
                                 got_cnt - base_got, exp_beat.last, res_o.last);
                        err_cnt++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        int     beats;
        beats = frame_beats(DIM_T1) + frame_beats(DIM_T2) + frame_beats(DIM_T3A)
              + frame_beats(DIM_T3B) + frame_beats(DIM_T4) + frame_beats(DIM_T5);
        limit_ns = 4 * beats * PAD_FRAME * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog: the run did not finish within %0d ns", limit_ns);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        arst_n_i   = 1'b0;
        fm_dim_i   = '0;
        wt_data_i  = '0;
        wt_valid_i = 1'b0;
        fm_data_i  = '0;
        fm_valid_i = 1'b0;
        bp_on      = 1'b0;
        got_cnt    = 0;
        err_cnt    = 0;
        tests_run  = 0;
        repeat (3) @(negedge clk);
        arst_n_i = 1'b1;

        start_test("identity");
        for (int i = 0; i < WT_DIM * WT_DIM; i++) begin
            kern[i] = '0;
        end
        kern[PAD * WT_DIM + PAD] = 16'd1;
        for (int i = 0; i < DIM_T1 * DIM_T1; i++) begin
            fm_mem[i] = conv2d_pkg::data_t'(i + 1);
        end
        run_frame(DIM_T1);
        finish_test(DIM_T1 * DIM_T1);

        start_test("random_kernel");
        randomize_kernel(16'h00ff, 16'h0000);
        randomize_map(DIM_T2, 16'h00ff, 16'h0000);
        run_frame(DIM_T2);
        finish_test(DIM_T2 * DIM_T2);

        // second kernel load waits for the first frame to drain
        start_test("back_to_back");
        randomize_kernel(16'h000f, 16'h0000);
        randomize_map(DIM_T3A, 16'h00ff, 16'h0000);
        run_frame(DIM_T3A);
        randomize_kernel(16'h00ff, 16'h0000);
        randomize_map(DIM_T3B, 16'h0fff, 16'h0000);
        run_frame(DIM_T3B);
        finish_test(DIM_T3A * DIM_T3A + DIM_T3B * DIM_T3B);

        start_test("backpressure");
        bp_on = 1'b1;
        randomize_kernel(16'h00ff, 16'h0000);
        randomize_map(DIM_T4, 16'h00ff, 16'h0000);
        run_frame(DIM_T4);
        finish_test(DIM_T4 * DIM_T4);
        bp_on = 1'b0;

        start_test("wraparound");
        randomize_kernel(16'hffff, 16'hf000);
        randomize_map(DIM_T5, 16'hffff, 16'hf000);
        kern[0]   = 16'hffff;
        fm_mem[0] = 16'hffff;
        run_frame(DIM_T5);
        finish_test(DIM_T5 * DIM_T5);

        // room for any stray extra result to show up
        repeat (20) @(negedge clk);
        if (dut0.u_props.fail_cnt != 0) begin
            $display("error: %0d handshake assertions failed during the run",
                     dut0.u_props.fail_cnt);
            err_cnt = err_cnt + dut0.u_props.fail_cnt;
        end
        $display("summary: %0d tests, %0d results checked, %0d errors",
                 tests_run, got_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: conv2d_props.sv
// handshake stability, ready exclusion and load ordering assertions
`timescale 1ns/100ps
`default_nettype none

module conv2d_props (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  conv2d_pkg::data_t     wt_data_i,
    input  logic                  wt_valid_i,
    input  logic                  wt_ready_i,
    input  conv2d_pkg::data_t     fm_data_i,
    input  logic                  fm_valid_i,
    input  logic                  fm_ready_i,
    input  conv2d_pkg::res_beat_t res_data_i,
    input  logic                  res_valid_i,
    input  logic                  res_ready_i,
    input  logic                  weights_loaded_i
);

    logic load_seen_q;
    // number of failed assertions
    int   fail_cnt = 0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            load_seen_q <= 1'b0;
        end else if (weights_loaded_i) begin
            load_seen_q <= 1'b1;
        end
    end

    wt_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        wt_valid_i && !wt_ready_i |=> wt_valid_i && $stable(wt_data_i))
        else begin
            $error("weight beat changed before it was accepted");
            fail_cnt++;
        end

    fm_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        fm_valid_i && !fm_ready_i |=> fm_valid_i && $stable(fm_data_i))
        else begin
            $error("pixel beat changed before it was accepted");
            fail_cnt++;
        end

    res_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_data_i))
        else begin
            $error("result beat changed before it was accepted");
            fail_cnt++;
        end

    // kernel load and pixel intake never overlap
    ready_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(fm_ready_i && wt_ready_i))
        else begin
            $error("pixel and weight ready both high");
            fail_cnt++;
        end

    res_after_load: assert property (@(posedge clk) disable iff (!arst_n_i)
        !load_seen_q |-> !res_valid_i)
        else begin
            $error("result valid before any kernel load");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: conv2d_top.sv
// conv2d_top: halo generator, line buffer, pe array and result FIFO of the engine
`timescale 1ns/100ps
`default_nettype none

module conv2d_top #(
    parameter int FM_MAX     = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  conv2d_pkg::coord_t    fm_dim_i,
    input  conv2d_pkg::data_t     wt_data_i,
    input  logic                  wt_valid_i,
    output logic                  wt_ready_o,
    input  conv2d_pkg::data_t     fm_data_i,
    input  logic                  fm_valid_i,
    output logic                  fm_ready_o,
    output conv2d_pkg::res_beat_t res_o,
    output logic                  res_valid_o,
    input  logic                  res_ready_i
);

    logic                  weights_loaded;
    logic                  almost_full;
    conv2d_pkg::pix_beat_t pix;
    logic                  pix_valid;
    conv2d_pkg::col_beat_t col;
    logic                  col_valid;
    conv2d_pkg::res_beat_t res;
    logic                  res_valid;

    conv_halo_gen u_halo_gen (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .fm_dim_i         (fm_dim_i),
        .fm_data_i        (fm_data_i),
        .fm_valid_i       (fm_valid_i),
        .fm_ready_o       (fm_ready_o),
        .weights_loaded_i (weights_loaded),
        .almost_full_i    (almost_full),
        .pix_o            (pix),
        .pix_valid_o      (pix_valid)
    );

    conv_line_buffer #(.FM_MAX(FM_MAX)) u_line_buffer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pix_i       (pix),
        .pix_valid_i (pix_valid),
        .col_o       (col),
        .col_valid_o (col_valid)
    );

    conv_pe_array u_pe_array (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .wt_data_i        (wt_data_i),
        .wt_valid_i       (wt_valid_i),
        .wt_ready_o       (wt_ready_o),
        .col_i            (col),
        .col_valid_i      (col_valid),
        .weights_loaded_o (weights_loaded),
        .res_o            (res),
        .res_valid_o      (res_valid)
    );

    conv_fifo #(.DEPTH(FIFO_DEPTH), .T(conv2d_pkg::res_beat_t)) u_res_fifo (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .wr_data_i     (res),
        .wr_valid_i    (res_valid),
        .rd_data_o     (res_o),
        .rd_valid_o    (res_valid_o),
        .rd_ready_i    (res_ready_i),
        .almost_full_o (almost_full)
    );

endmodule

`default_nettype wire

// File: conv_fifo.sv
// conv_fifo: synchronous circular FIFO with a payload type parameter and almost-full flag
`timescale 1ns/100ps
`default_nettype none

module conv_fifo #(
    parameter int  DEPTH = 8,
    parameter type T     = logic
) (
    input  logic clk,
    input  logic arst_n_i,
    input  T     wr_data_i,
    input  logic wr_valid_i,
    output T     rd_data_o,
    output logic rd_valid_o,
    input  logic rd_ready_i,
    output logic almost_full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_MAX = PTR_W'(DEPTH - 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             rd_fire;

    assign rd_valid_o    = (count_q != '0);
    assign rd_data_o     = mem[rd_ptr_q];
    assign rd_fire       = rd_valid_o & rd_ready_i;
    // leaves room for the beats still in the pipeline
    assign almost_full_o = (count_q >= CNT_W'(DEPTH - 4));

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_MAX) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr_q <= (rd_ptr_q == PTR_MAX) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_valid_i, rd_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: conv_pe_array.sv
// conv_pe_array: weight load sequencing, pe row instances, result sum and output validity
`timescale 1ns/100ps
`default_nettype none

module conv_pe_array (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  conv2d_pkg::data_t     wt_data_i,
    input  logic                  wt_valid_i,
    output logic                  wt_ready_o,
    input  conv2d_pkg::col_beat_t col_i,
    input  logic                  col_valid_i,
    output logic                  weights_loaded_o,
    output conv2d_pkg::res_beat_t res_o,
    output logic                  res_valid_o
);

    localparam int WT_DIM = conv2d_pkg::WT_DIM;
    localparam conv2d_pkg::wt_idx_t IDX_MAX = conv2d_pkg::wt_idx_t'(WT_DIM - 1);
    localparam conv2d_pkg::coord_t  EDGE    = conv2d_pkg::coord_t'(WT_DIM - 1);

    conv2d_pkg::wt_idx_t m_q;
    conv2d_pkg::wt_idx_t n_q;
    logic                loaded_q;
    logic                wt_ready_q;
    logic                wt_fire;
    logic                last_wt;
    logic                frame_done;
    conv2d_pkg::data_t   row_sum [WT_DIM];
    conv2d_pkg::data_t   sum_d;
    conv2d_pkg::coord_t  win_x_q;
    conv2d_pkg::coord_t  win_y_q;
    logic                win_last_q;
    logic                win_valid_q;

    assign wt_ready_o       = wt_ready_q;
    assign weights_loaded_o = loaded_q;
    assign wt_fire          = wt_valid_i & wt_ready_q;
    assign last_wt          = wt_fire & (m_q == IDX_MAX) & (n_q == IDX_MAX);
    assign frame_done       = res_valid_o & res_o.last;

    // row-major weight load, m picks the pe and n the column
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_q        <= '0;
            n_q        <= '0;
            loaded_q   <= 1'b0;
            wt_ready_q <= 1'b0;
        end else begin
            if (wt_fire) begin
                if (n_q == IDX_MAX) begin
                    n_q <= '0;
                    m_q <= (m_q == IDX_MAX) ? '0 : m_q + 1'b1;
                end else begin
                    n_q <= n_q + 1'b1;
                end
            end
            if (last_wt) begin
                loaded_q   <= 1'b1;
                wt_ready_q <= 1'b0;
            end else if (frame_done) begin
                loaded_q   <= 1'b0;
                wt_ready_q <= 1'b1;
            end else begin
                wt_ready_q <= ~loaded_q;
            end
        end
    end

    for (genvar m = 0; m < WT_DIM; m++) begin : g_pe
        conv_pe u_pe (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .wt_data_i   (wt_data_i),
            .wt_we_i     (wt_fire && (m_q == conv2d_pkg::wt_idx_t'(m))),
            .wt_col_i    (n_q),
            .wt_clear_i  (frame_done),
            .tap_i       (col_i.taps[m]),
            .tap_valid_i (col_valid_i),
            .row_sum_o   (row_sum[m])
        );
    end

    always_comb begin
        sum_d = '0;
        for (int k = 0; k < WT_DIM; k++) begin
            sum_d = sum_d + row_sum[k];
        end
    end

    // coordinates follow the pe windows by one cycle
    always_ff @(posedge clk) begin
        if (col_valid_i) begin
            win_x_q    <= col_i.x;
            win_y_q    <= col_i.y;
            win_last_q <= col_i.last;
        end
        if (win_valid_q) begin
            res_o.data <= sum_d;
            res_o.last <= win_last_q;
        end
    end

    // a window is complete once it spans WT_DIM rows and columns
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            win_valid_q <= 1'b0;
            res_valid_o <= 1'b0;
        end else begin
            win_valid_q <= col_valid_i;
            res_valid_o <= win_valid_q && (win_x_q >= EDGE) && (win_y_q >= EDGE);
        end
    end

endmodule

`default_nettype wire

// File: conv_pe.sv
// conv_pe: one kernel row with its horizontal pixel window and row dot product
`timescale 1ns/100ps
`default_nettype none

module conv_pe (
    input  logic                clk,
    input  logic                arst_n_i,
    input  conv2d_pkg::data_t   wt_data_i,
    input  logic                wt_we_i,
    input  conv2d_pkg::wt_idx_t wt_col_i,
    input  logic                wt_clear_i,
    input  conv2d_pkg::data_t   tap_i,
    input  logic                tap_valid_i,
    output conv2d_pkg::data_t   row_sum_o
);

    localparam int WT_DIM = conv2d_pkg::WT_DIM;

    conv2d_pkg::data_t weight_q [WT_DIM];
    // window_q[0] is the newest pixel
    conv2d_pkg::data_t window_q [WT_DIM];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < WT_DIM; k++) begin
                weight_q[k] <= '0;
                window_q[k] <= '0;
            end
        end else if (wt_clear_i) begin
            for (int k = 0; k < WT_DIM; k++) begin
                weight_q[k] <= '0;
                window_q[k] <= '0;
            end
        end else begin
            if (wt_we_i) begin
                weight_q[wt_col_i] <= wt_data_i;
            end
            if (tap_valid_i) begin
                window_q[0] <= tap_i;
                for (int k = 1; k < WT_DIM; k++) begin
                    window_q[k] <= window_q[k-1];
                end
            end
        end
    end

    // newest pixel meets the rightmost kernel column, wraps at DATA_W
    always_comb begin
        row_sum_o = '0;
        for (int k = 0; k < WT_DIM; k++) begin
            row_sum_o = row_sum_o + window_q[k] * weight_q[WT_DIM-1-k];
        end
    end

endmodule

`default_nettype wire

// File: conv_line_buffer.sv
// conv_line_buffer: row memories that turn padded pixels into vertical pixel columns
`timescale 1ns/100ps
`default_nettype none

module conv_line_buffer #(
    parameter int FM_MAX = 8
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  conv2d_pkg::pix_beat_t pix_i,
    input  logic                  pix_valid_i,
    output conv2d_pkg::col_beat_t col_o,
    output logic                  col_valid_o
);

    localparam int WT_DIM = conv2d_pkg::WT_DIM;
    localparam int DEPTH  = FM_MAX + WT_DIM - 1;
    localparam int ADDR_W = $clog2(DEPTH);

    // row 0 is the oldest stored row
    conv2d_pkg::data_t rows_q [WT_DIM-1][DEPTH];
    logic [ADDR_W-1:0] addr;

    assign addr = pix_i.x[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (pix_valid_i) begin
            for (int r = 0; r < WT_DIM - 1; r++) begin
                col_o.taps[r] <= rows_q[r][addr];
            end
            col_o.taps[WT_DIM-1] <= pix_i.data;
            col_o.x              <= pix_i.x;
            col_o.y              <= pix_i.y;
            col_o.last           <= pix_i.last;

            // each row moves one step older at this column
            for (int r = 0; r < WT_DIM - 2; r++) begin
                rows_q[r][addr] <= rows_q[r+1][addr];
            end
            rows_q[WT_DIM-2][addr] <= pix_i.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_valid_o <= 1'b0;
        end else begin
            col_valid_o <= pix_valid_i;
        end
    end

endmodule

`default_nettype wire

// File: conv_halo_gen.sv
// conv_halo_gen: padded frame walker with zero halo insertion and input throttling
`timescale 1ns/100ps
`default_nettype none

module conv_halo_gen (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  conv2d_pkg::coord_t    fm_dim_i,
    input  conv2d_pkg::data_t     fm_data_i,
    input  logic                  fm_valid_i,
    output logic                  fm_ready_o,
    input  logic                  weights_loaded_i,
    input  logic                  almost_full_i,
    output conv2d_pkg::pix_beat_t pix_o,
    output logic                  pix_valid_o
);

    localparam int PAD = conv2d_pkg::PAD;

    conv2d_pkg::coord_t x_q;
    conv2d_pkg::coord_t y_q;
    conv2d_pkg::coord_t inner_end;
    conv2d_pkg::coord_t last_pos;
    logic               halo;
    logic               can_go;
    logic               advance;
    logic               x_wrap;
    logic               y_wrap;
    logic               done_q;

    // first halo index past the interior, and the last padded index
    assign inner_end = fm_dim_i + conv2d_pkg::coord_t'(PAD);
    assign last_pos  = fm_dim_i + conv2d_pkg::coord_t'(2 * PAD - 1);

    assign halo = (x_q < conv2d_pkg::coord_t'(PAD)) | (y_q < conv2d_pkg::coord_t'(PAD))
                | (x_q >= inner_end) | (y_q >= inner_end);

    assign x_wrap = (x_q == last_pos);
    assign y_wrap = (y_q == last_pos);

    // done_q parks the walker between the frame end and the next kernel load
    assign can_go     = weights_loaded_i & ~done_q & ~almost_full_i;
    assign advance    = can_go & (halo | fm_valid_i);
    assign fm_ready_o = can_go & ~halo;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            x_q         <= '0;
            y_q         <= '0;
            done_q      <= 1'b0;
            pix_valid_o <= 1'b0;
        end else begin
            pix_valid_o <= advance;
            if (!weights_loaded_i) begin
                done_q <= 1'b0;
            end else if (advance && x_wrap && y_wrap) begin
                done_q <= 1'b1;
            end
            if (advance) begin
                if (x_wrap) begin
                    x_q <= '0;
                    y_q <= y_wrap ? '0 : y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pix_o.data <= halo ? '0 : fm_data_i;
            pix_o.x    <= x_q;
            pix_o.y    <= y_q;
            pix_o.last <= x_wrap & y_wrap;
        end
    end

endmodule

`default_nettype wire

// File: conv2d_pkg.sv
// width constants, index types and packed stream beats of the 2d convolution engine
`default_nettype none

package conv2d_pkg;

    localparam int DATA_W  = 16;
    localparam int COORD_W = 8;
    // kernel side, must be odd
    localparam int WT_DIM  = 3;
    localparam int PAD     = WT_DIM / 2;
    localparam int WT_IDX_W = $clog2(WT_DIM);

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [COORD_W-1:0]  coord_t;
    typedef logic [WT_IDX_W-1:0] wt_idx_t;

    // one padded pixel, last marks the final padded position
    typedef struct packed {
        data_t  data;
        coord_t x;
        coord_t y;
        logic   last;
    } pix_beat_t;

    // one vertical column, tap 0 holds the oldest row
    typedef struct packed {
        data_t [WT_DIM-1:0] taps;
        coord_t             x;
        coord_t             y;
        logic               last;
    } col_beat_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } res_beat_t;

endpackage

`default_nettype wire
